// ==== icache.f ====
+incdir+testbench
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache.sv
testbench/mem_model.sv
testbench/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the cache testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module icache_tb -f icache.f -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== src/icache.sv ====
// instruction cache top level
// wires controller, stores, lookup and refill together
`timescale 1ns/1ps

module icache import icache_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,

   // processor side
   input  logic                   ce,
   input  logic [addr_width-1:0]  addr,
   output logic                   ce_ready,
   output logic [word_width-1:0]  rdata,
   output logic                   rdata_valid,
   input  logic                   rdata_ready,

   // memory side
   output logic [addr_width-1:0]  mem_addr,
   output logic                   mem_ce,
   input  logic [word_width-1:0]  mem_rdata,
   input  logic                   mem_rdata_valid
);

   cache_addr_t                         req_addr;
   logic [index_bits-1:0]               rd_index;
   logic                                lookup_en;
   logic                                refill_start;
   logic                                fill_we;
   logic                                lru_we;

   logic [num_ways-1:0][tag_bits-1:0]   way_tag;
   logic [num_ways-1:0]                 way_valid;
   logic                                lru;
   logic [num_ways-1:0][word_width-1:0] way_word;

   logic                                hit;
   logic                                hit_way;
   logic                                victim_way;
   logic [word_width-1:0]               hit_word;
   logic                                lru_victim;

   logic                                refill_done;
   logic [line_bits-1:0]                line_buf;
   logic [word_width-1:0]               miss_word;

   icache_ctrl u_ctrl (
      .clk          (clk),
      .reset        (reset),
      .ce           (ce),
      .addr         (addr),
      .rdata_ready  (rdata_ready),
      .ce_ready     (ce_ready),
      .rdata        (rdata),
      .rdata_valid  (rdata_valid),
      .hit          (hit),
      .refill_done  (refill_done),
      .hit_word     (hit_word),
      .miss_word    (miss_word),
      .req_addr     (req_addr),
      .rd_index     (rd_index),
      .lookup_en    (lookup_en),
      .refill_start (refill_start),
      .fill_we      (fill_we),
      .lru_we       (lru_we)
   );

   // fills go to the victim way of the request set
   icache_tag_store u_tag_store (
      .clk        (clk),
      .reset      (reset),
      .rd_index   (rd_index),
      .wr_index   (req_addr.fields.index),
      .fill_we    (fill_we),
      .fill_way   (victim_way),
      .fill_tag   (req_addr.fields.tag),
      .lru_we     (lru_we),
      .lru_victim (lru_victim),
      .way_tag    (way_tag),
      .way_valid  (way_valid),
      .lru        (lru)
   );

   icache_data_store u_data_store (
      .clk       (clk),
      .rd_index  (rd_index),
      .word_sel  (req_addr.fields.word),
      .fill_we   (fill_we),
      .fill_way  (victim_way),
      .wr_index  (req_addr.fields.index),
      .fill_line (line_buf),
      .way_word  (way_word)
   );

   icache_lookup u_lookup (
      .req_addr   (req_addr),
      .way_tag    (way_tag),
      .way_valid  (way_valid),
      .lru        (lru),
      .way_word   (way_word),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .hit_word   (hit_word),
      .lru_victim (lru_victim)
   );

   icache_refill u_refill (
      .clk             (clk),
      .reset           (reset),
      .refill_start    (refill_start),
      .req_addr        (req_addr),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_ce          (mem_ce),
      .mem_addr        (mem_addr),
      .refill_done     (refill_done),
      .line_buf        (line_buf),
      .miss_word       (miss_word)
   );

endmodule

// ==== src/icache_ctrl.sv ====
// request capture and response register
// idle / lookup / refill / respond FSM, store write strobes
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,

   // processor side
   input  logic                   ce,
   input  logic [addr_width-1:0]  addr,
   input  logic                   rdata_ready,
   output logic                   ce_ready,
   output logic [word_width-1:0]  rdata,
   output logic                   rdata_valid,

   // stage status
   input  logic                   hit,
   input  logic                   refill_done,
   input  logic [word_width-1:0]  hit_word,
   input  logic [word_width-1:0]  miss_word,

   output cache_addr_t            req_addr,
   output logic [index_bits-1:0]  rd_index,
   output logic                   lookup_en,
   output logic                   refill_start,
   output logic                   fill_we,
   output logic                   lru_we
);

   ctrl_state_t state;
   logic        accept;
   logic        hit_done;

   assign ce_ready = (state == state_idle);
   assign accept   = ce && ce_ready;

   // lookup takes two cycles, compare is valid in the second
   assign hit_done     = (state == state_lookup) && lookup_en && hit;
   assign refill_start = (state == state_lookup) && lookup_en && !hit;
   assign fill_we      = (state == state_refill) && refill_done;
   assign lru_we       = hit_done || fill_we;

   assign rd_index    = req_addr.fields.index;
   assign rdata_valid = (state == state_respond);

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= state_idle;
         lookup_en <= 1'b0;
      end else begin
         lookup_en <= (state == state_lookup) && !lookup_en;
         case (state)
            state_idle:    if (accept) state <= state_lookup;
            state_lookup:  if (lookup_en) state <= hit ? state_respond : state_refill;
            state_refill:  if (refill_done) state <= state_respond;
            state_respond: if (rdata_ready) state <= state_idle;
            default:       state <= state_idle;
         endcase
      end
   end

   // request address and response word
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
      end
      if (hit_done) begin
         rdata <= hit_word;
      end else if (fill_we) begin
         rdata <= miss_word;
      end
   end

endmodule

// ==== src/icache_data_store.sv ====
// line data array per way with registered read
// word selection happens inside, only one word per way goes out
`timescale 1ns/1ps

module icache_data_store import icache_pkg::*; (
   input  logic                                 clk,

   input  logic [index_bits-1:0]                rd_index,
   input  logic [word_sel_bits-1:0]             word_sel,

   // fill port
   input  logic                                 fill_we,
   input  logic                                 fill_way,
   input  logic [index_bits-1:0]                wr_index,
   input  logic [line_bits-1:0]                 fill_line,

   output logic [num_ways-1:0][word_width-1:0]  way_word
);

   logic [line_bits-1:0] line_mem [num_ways][num_sets];

   // registered line from each way
   logic [num_ways-1:0][line_bits-1:0] line_q;

   always_ff @(posedge clk) begin
      if (fill_we) begin
         line_mem[fill_way][wr_index] <= fill_line;
      end
      for (int w = 0; w < num_ways; w++) begin
         line_q[w] <= line_mem[w][rd_index];
      end
   end

   // word 0 sits in the low bits of the line
   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         way_word[w] = line_q[w][word_sel*word_width +: word_width];
      end
   end

endmodule

// ==== src/icache_lookup.sv ====
// tag compare across ways, hit way and hit word select
// victim choice and next lru value
`timescale 1ns/1ps

module icache_lookup import icache_pkg::*; (
   input  cache_addr_t                          req_addr,

   // registered store outputs for the request set
   input  logic [num_ways-1:0][tag_bits-1:0]    way_tag,
   input  logic [num_ways-1:0]                  way_valid,
   input  logic                                 lru,
   input  logic [num_ways-1:0][word_width-1:0]  way_word,

   output logic                                 hit,
   output logic                                 hit_way,
   output logic                                 victim_way,
   output logic [word_width-1:0]                hit_word,
   output logic                                 lru_victim
);

   logic [num_ways-1:0] way_hit;

   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         way_hit[w] = way_valid[w] && (way_tag[w] == req_addr.fields.tag);
      end
   end

   assign hit = |way_hit;

   // a line lives in one way only, so any match is the match
   always_comb begin
      hit_way = 1'b0;
      for (int w = 0; w < num_ways; w++) begin
         if (way_hit[w]) begin
            hit_way = 1'(w);
         end
      end
   end

   assign hit_word = way_word[hit_way];

   // evict the least recently used way
   assign victim_way = lru;

   // after a hit or a fill the other way becomes lru
   assign lru_victim = hit ? ~hit_way : ~victim_way;

endmodule

// ==== src/icache_pkg.sv ====
// instruction cache geometry constants
// request address union with field and line views
// controller state encoding
package icache_pkg;

   // basic widths
   localparam int addr_width = 32;
   localparam int word_width = 32;

   // geometry, 4 KB over two ways
   localparam int line_words = 16;
   localparam int num_ways   = 2;
   localparam int num_sets   = 32;

   // address split
   localparam int byte_bits      = $clog2(word_width / 8);
   localparam int word_sel_bits  = $clog2(line_words);
   localparam int offset_bits    = word_sel_bits + byte_bits;
   localparam int index_bits     = $clog2(num_sets);
   localparam int tag_bits       = addr_width - index_bits - offset_bits;
   localparam int line_bits      = word_width * line_words;
   localparam int line_addr_bits = addr_width - offset_bits;

   // lookup and the stores decode tag/index/word
   typedef struct packed {
      logic [tag_bits-1:0]      tag;
      logic [index_bits-1:0]    index;
      logic [word_sel_bits-1:0] word;
      logic [byte_bits-1:0]     byte_sel;
   } addr_fields_t;

   // refill only needs the line number
   typedef struct packed {
      logic [line_addr_bits-1:0] line_addr;
      logic [offset_bits-1:0]    offset;
   } addr_line_t;

   typedef union packed {
      addr_fields_t fields;
      addr_line_t   line;
   } cache_addr_t;

   typedef enum logic [1:0] {
      state_idle,
      state_lookup,
      state_refill,
      state_respond
   } ctrl_state_t;

endpackage

// ==== src/icache_refill.sv ====
// miss refill: burst address generator and word counter
// line assembly buffer and miss word select
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,

   input  logic                   refill_start,
   input  cache_addr_t            req_addr,

   // memory read burst
   input  logic [word_width-1:0]  mem_rdata,
   input  logic                   mem_rdata_valid,
   output logic                   mem_ce,
   output logic [addr_width-1:0]  mem_addr,

   output logic                   refill_done,
   output logic [line_bits-1:0]   line_buf,
   output logic [word_width-1:0]  miss_word
);

   logic                     active;
   logic [word_sel_bits-1:0] word_cnt;
   logic                     take;

   assign take = active && mem_rdata_valid;

   // burst control
   always_ff @(posedge clk) begin
      if (reset) begin
         active      <= 1'b0;
         word_cnt    <= '0;
         refill_done <= 1'b0;
      end else begin
         refill_done <= 1'b0;
         if (refill_start) begin
            active   <= 1'b1;
            word_cnt <= '0;
         end else if (take) begin
            word_cnt <= word_cnt + 1'b1;
            // last word of the line
            if (word_cnt == '1) begin
               active      <= 1'b0;
               refill_done <= 1'b1;
            end
         end
      end
   end

   // address and line data
   always_ff @(posedge clk) begin
      if (refill_start) begin
         mem_addr <= {req_addr.line.line_addr, {offset_bits{1'b0}}};
      end else if (take) begin
         mem_addr <= mem_addr + addr_width'(word_width / 8);
         // words enter at the top, word 0 ends up lowest
         line_buf <= {mem_rdata, line_buf[line_bits-1:word_width]};
      end
   end

   assign mem_ce = active;

   assign miss_word = line_buf[req_addr.fields.word*word_width +: word_width];

endmodule

// ==== src/icache_tag_store.sv ====
// tag array per way with registered read
// valid bits per way and LRU bit per set, both cleared by reset
`timescale 1ns/1ps

module icache_tag_store import icache_pkg::*; (
   input  logic                               clk,
   input  logic                               reset,

   input  logic [index_bits-1:0]              rd_index,
   input  logic [index_bits-1:0]              wr_index,

   // line fill from the refill path
   input  logic                               fill_we,
   input  logic                               fill_way,
   input  logic [tag_bits-1:0]                fill_tag,

   // replacement update
   input  logic                               lru_we,
   input  logic                               lru_victim,

   output logic [num_ways-1:0][tag_bits-1:0]  way_tag,
   output logic [num_ways-1:0]                way_valid,
   output logic                               lru
);

   logic [tag_bits-1:0] tag_mem [num_ways][num_sets];

   logic [num_ways-1:0][num_sets-1:0] valid_bits;
   logic [num_sets-1:0]               lru_bits;

   // tag ram, read returns old contents on a same-edge write
   always_ff @(posedge clk) begin
      if (fill_we) begin
         tag_mem[fill_way][wr_index] <= fill_tag;
      end
      for (int w = 0; w < num_ways; w++) begin
         way_tag[w] <= tag_mem[w][rd_index];
      end
   end

   // valid and lru state
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         lru_bits   <= '0;
         way_valid  <= '0;
         lru        <= 1'b0;
      end else begin
         if (fill_we) begin
            valid_bits[fill_way][wr_index] <= 1'b1;
         end
         // lru names the way evicted next
         if (lru_we) begin
            lru_bits[wr_index] <= lru_victim;
         end
         for (int w = 0; w < num_ways; w++) begin
            way_valid[w] <= valid_bits[w][rd_index];
         end
         lru <= lru_bits[rd_index];
      end
   end

endmodule

// ==== testbench/tb_common.svh ====
// memory contents pattern and LCG step shared by the testbench files
`ifndef TB_COMMON_SVH
`define TB_COMMON_SVH

// word at a byte address, mixes every address bit with a constant
function automatic logic [31:0] mem_word(input logic [31:0] a);
   logic [31:0] w;
   w = {a[31:2], 2'b00};
   return (w * 32'h9e37_79b9) ^ {w[15:0], w[31:16]} ^ 32'h3c5a_a5c3;
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== testbench/icache_tb.sv ====
// testbench for the instruction cache
// reference tag/lru model, response compare, burst monitor and timeout
`timescale 1ns/1ps
`include "tb_common.svh"

module icache_tb import icache_pkg::*; ();

   localparam int cycle_limit = 300 * (16 * 4 + 20);

   logic clk, reset, ce, rdata_ready, ce_ready, rdata_valid, mem_ce, mem_rdata_valid;
   logic [31:0] addr, rdata, mem_addr, mem_rdata;

   logic [20:0]         ref_tag [2][num_sets];
   logic                ref_valid [2][num_sets];
   logic                ref_lru [num_sets];
   int                  ref_misses, errors, checks, cycles, burst_count, beat;
   logic [31:0]         exp_q [$];
   logic [31:0]         rng, cur_addr, burst_base, held_data;
   logic                mem_ce_q, hold_pending;

   icache dut_i (
      .clk(clk), .reset(reset), .ce(ce), .addr(addr), .ce_ready(ce_ready),
      .rdata(rdata), .rdata_valid(rdata_valid), .rdata_ready(rdata_ready),
      .mem_addr(mem_addr), .mem_ce(mem_ce), .mem_rdata(mem_rdata),
      .mem_rdata_valid(mem_rdata_valid)
   );

   mem_model mem_i (
      .clk(clk), .reset(reset), .mem_ce(mem_ce), .mem_addr(mem_addr),
      .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // expected word for a request
   function automatic logic [31:0] expected_word(input logic [31:0] a);
      return mem_word({a[31:2], 2'b00});
   endfunction

   // reference lookup, returns 1 on a hit and updates tags and lru
   function automatic logic ref_access(input logic [31:0] a);
      logic [4:0]  idx;
      logic [20:0] tag;
      logic        way;
      // 64-byte lines, 32 sets
      idx = a[10:6];
      tag = a[31:11];
      for (int w = 0; w < 2; w++) begin
         if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
            ref_lru[idx] = ~1'(w);
            return 1'b1;
         end
      end
      way = ref_lru[idx];
      ref_tag[way][idx]   = tag;
      ref_valid[way][idx] = 1'b1;
      ref_lru[idx]        = ~way;
      ref_misses++;
      return 1'b0;
   endfunction

   // one request; bp holds rdata_ready low for a random time
   task automatic do_request(input logic [31:0] a, input logic bp);
      logic        exp_hit;
      int          bursts_before, waits;
      logic [31:0] hold;
      while (!ce_ready) @(negedge clk);
      exp_hit       = ref_access(a);
      bursts_before = burst_count;
      exp_q.push_back(expected_word(a));
      cur_addr    = a;
      ce          = 1'b1;
      addr        = a;
      rdata_ready = !bp;
      @(negedge clk);
      ce    = 1'b0;
      waits = 1;
      while (!rdata_valid) begin
         @(negedge clk);
         waits++;
      end
      if (exp_hit) begin
         check_value(32'(waits), 32'd3, "hit latency in cycles");
         check_value(32'(burst_count - bursts_before), 32'd0, "bursts on a hit");
      end else begin
         check_value(32'(burst_count - bursts_before), 32'd1, "bursts on a miss");
      end
      if (bp) begin
         rng  = lcg_next(rng);
         hold = (rng >> 16) % 32'd5;
         repeat (hold) @(negedge clk);
         rdata_ready = 1'b1;
      end
      @(negedge clk);
   endtask

   // response compare and back-pressure stability
   always @(posedge clk) begin
      if (!reset) begin
         if (hold_pending) begin
            check_value(32'(rdata_valid), 32'd1, "rdata_valid dropped while stalled");
            check_value(rdata, held_data, "rdata changed while stalled");
            check_value(32'(ce_ready), 32'd0, "ce_ready high while stalled");
         end
         if (rdata_valid && rdata_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("response at %0t ns with no request outstanding", $time);
            end else begin
               check_value(rdata, exp_q.pop_front(), "read data");
            end
         end
         hold_pending = rdata_valid && !rdata_ready;
         held_data    = rdata;
      end
   end

   // burst monitor, sixteen words from the line base upward
   always @(posedge clk) begin
      if (!reset) begin
         if (mem_ce && !mem_ce_q) begin
            beat       = 0;
            burst_base = {cur_addr[31:6], 6'b0};
         end
         if (mem_ce && mem_rdata_valid) begin
            check_value(mem_addr, burst_base + 32'(beat * 4), "burst address");
            beat++;
         end
         if (!mem_ce && mem_ce_q) begin
            check_value(32'(beat), 32'd16, "words in burst");
            burst_count++;
         end
      end
      mem_ce_q = mem_ce;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: no finish after %0d cycles", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      logic [31:0] a;
      reset = 1'b1;
      ce = 1'b0;
      addr = 32'd0;
      rdata_ready = 1'b1;
      rng = 32'hfe1c;
      errors = 0;
      checks = 0;
      cycles = 0;
      burst_count = 0;
      beat = 0;
      ref_misses = 0;
      mem_ce_q = 1'b0;
      hold_pending = 1'b0;
      burst_base = 32'd0;
      cur_addr = 32'd0;
      for (int s = 0; s < num_sets; s++) begin
         ref_lru[s] = 1'b0;
         for (int w = 0; w < 2; w++) begin
            ref_valid[w][s] = 1'b0;
            ref_tag[w][s]   = '0;
         end
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // cold miss, then every word of that line hits
      do_request(32'h0000_0124, 1'b0);
      for (int i = 0; i < 16; i++) do_request(32'h0000_0100 + 32'(i * 4), 1'b0);

      // three lines in set 5
      do_request(32'h0000_0940, 1'b0);
      do_request(32'h0000_1144, 1'b0);
      do_request(32'h0000_0948, 1'b0);
      do_request(32'h0000_114c, 1'b0);
      do_request(32'h0000_1950, 1'b0);
      do_request(32'h0000_1154, 1'b0);
      do_request(32'h0000_0958, 1'b0);
      do_request(32'h0000_195c, 1'b0);

      // stalled responses on hits and misses
      for (int i = 0; i < 20; i++) begin
         rng = lcg_next(rng);
         do_request(((rng >> 8) % 32'd1024) << 2, 1'b1);
      end

      for (int i = 0; i < 200; i++) begin
         rng = lcg_next(rng);
         a   = ((rng >> 8) % 32'd4096) << 2;
         do_request(a, 1'b0);
      end

      repeat (4) @(negedge clk);
      check_value(32'(burst_count), 32'(ref_misses), "refill bursts against model misses");
      check_value(32'(exp_q.size()), 32'd0, "responses outstanding");
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== testbench/mem_model.sv ====
// memory model for the cache refill port
// answers burst reads one word at a time with random gaps
`timescale 1ns/1ps
`include "tb_common.svh"

module mem_model (
   input  logic         clk,
   input  logic         reset,
   input  logic         mem_ce,
   input  logic [31:0]  mem_addr,
   output logic [31:0]  mem_rdata,
   output logic         mem_rdata_valid
);

   logic [31:0] rng;
   logic [31:0] gap;

   initial begin
      rng             = 32'hfe1c;
      gap             = 32'd0;
      mem_rdata       = 32'd0;
      mem_rdata_valid = 1'b0;
   end

   // outputs change on the falling edge, the cache takes them on the rising one
   always @(negedge clk) begin
      mem_rdata_valid <= 1'b0;
      if (!reset && mem_ce) begin
         if (gap != 0) begin
            gap <= gap - 32'd1;
         end else begin
            mem_rdata       <= mem_word(mem_addr);
            mem_rdata_valid <= 1'b1;
            // 0 to 3 idle cycles before the next word
            rng = lcg_next(rng);
            gap <= (rng >> 16) % 32'd4;
         end
      end
   end

endmodule
